// ==== sparc_params.svh ====
`ifndef SPARC_PARAMS_SVH
`define SPARC_PARAMS_SVH

// Datapath width, shared by data and addresses
`define SPARC_WORD_W 32

// Register file geometry
`define SPARC_REG_IDX_W 5
`define SPARC_NUM_REGS 32

// Trap type field
`define SPARC_TT_W 3
`define SPARC_TT_ILLEGAL 3'd2 // Illegal instruction

// PC after reset, nPC follows at +4
`define SPARC_RESET_PC 32'h0000_0000

`endif

// ==== sparc_pkg.sv ====
`include "sparc_params.svh"

package sparc_pkg;

	typedef logic [`SPARC_WORD_W-1:0] word_t;       // Data or address
	typedef logic [`SPARC_REG_IDX_W-1:0] reg_idx_t; // Register number
	typedef logic [5:0] op3_t;                      // op3 field, doubles as ALU op
	typedef logic [1:0] ext_sel_t;                  // Extender form
	typedef logic [1:0] alub_sel_t;                 // ALU B source
	typedef logic pc_src_t;                         // nPC load source

	// op3 codes, arithmetic and logic group
	localparam op3_t OP3_ADD  = 6'h00;
	localparam op3_t OP3_AND  = 6'h01;
	localparam op3_t OP3_OR   = 6'h02;
	localparam op3_t OP3_XOR  = 6'h03;
	localparam op3_t OP3_SUB  = 6'h04;
	localparam op3_t OP3_ANDN = 6'h05;
	localparam op3_t OP3_ORN  = 6'h06;
	localparam op3_t OP3_XNOR = 6'h07;
	localparam op3_t OP3_JMPL = 6'h38;
	// op3 codes, memory group (op = 11)
	localparam op3_t OP3_LD   = 6'h00;
	localparam op3_t OP3_ST   = 6'h04;

	localparam ext_sel_t EXT_SIMM13 = 2'd0; // Sign extended simm13
	localparam ext_sel_t EXT_IMM22  = 2'd1; // SETHI immediate
	localparam ext_sel_t EXT_DISP30 = 2'd2; // CALL displacement

	localparam alub_sel_t ALUB_REG = 2'd0;
	localparam alub_sel_t ALUB_EXT = 2'd1;
	localparam alub_sel_t ALUB_PC  = 2'd2;
	localparam alub_sel_t ALUB_MDR = 2'd3;

	localparam pc_src_t NPC_SRC_INC = 1'b0;
	localparam pc_src_t NPC_SRC_ALU = 1'b1;

	localparam reg_idx_t REG_O7 = 5'd15; // CALL link register

	typedef enum logic [3:0] {
		IDLE, EXEC, WRITE, MEM_ADDR, MEM_WAIT, MEM_DATA, CALL_LINK, JMP_TARGET, FINISH
	} cu_state_t;

endpackage

// ==== operand_extender.sv ====
`timescale 1ns/1ps

module operand_extender (
	input  sparc_pkg::word_t    ir,
	input  sparc_pkg::ext_sel_t sel,
	output sparc_pkg::word_t    value
);
	import sparc_pkg::*;

	always_comb begin
		case (sel)
			EXT_SIMM13: value = {{19{ir[12]}}, ir[12:0]}; // Sign extended
			EXT_IMM22:  value = {ir[21:0], 10'b0};        // SETHI places it high
			EXT_DISP30: value = {ir[29:0], 2'b00};        // Word displacement
			default:    value = '0;
		endcase
	end

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
	input  sparc_pkg::op3_t      op,
	input  sparc_pkg::word_t     rdata_a,
	input  sparc_pkg::word_t     rdata_b,
	input  logic                 alua_is_zero,
	input  sparc_pkg::alub_sel_t alub_sel,
	input  sparc_pkg::ext_sel_t  ext_sel,
	input  sparc_pkg::word_t     ir,
	input  sparc_pkg::word_t     pc,
	input  sparc_pkg::word_t     mdr,
	output sparc_pkg::word_t     result
);
	import sparc_pkg::*;

	word_t ext_value;
	word_t a, b;

	operand_extender i_ext (
		.ir    (ir),
		.sel   (ext_sel),
		.value (ext_value)
	);

	assign a = alua_is_zero ? '0 : rdata_a; // Zero for pass-through moves

	always_comb begin
		case (alub_sel)
			ALUB_REG: b = rdata_b;
			ALUB_EXT: b = ext_value;
			ALUB_PC:  b = pc;
			default:  b = mdr;
		endcase
	end

	always_comb begin
		case (op)
			OP3_SUB:  result = a - b;
			OP3_AND:  result = a & b;
			OP3_OR:   result = a | b;
			OP3_XOR:  result = a ^ b;
			OP3_ANDN: result = a & ~b;
			OP3_ORN:  result = a | ~b;
			OP3_XNOR: result = ~(a ^ b);
			default:  result = a + b; // add, also address and link sums
		endcase
	end

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps
`include "sparc_params.svh"

module register_file (
	input  logic                Clk,
	input  logic                RESET,
	input  logic                write,
	input  sparc_pkg::reg_idx_t rs1_idx,
	input  sparc_pkg::reg_idx_t rs2_idx,
	input  sparc_pkg::reg_idx_t rd_idx,
	input  sparc_pkg::word_t    wdata,
	output sparc_pkg::word_t    rdata_a,
	output sparc_pkg::word_t    rdata_b
);
	import sparc_pkg::*;

	word_t regs [`SPARC_NUM_REGS];

	always_ff @(posedge Clk) begin
		if (RESET) begin
			for (int i = 0; i < `SPARC_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (write && rd_idx != '0) begin
			regs[rd_idx] <= wdata; // r0 writes are dropped
		end
	end

	// Asynchronous reads, r0 hardwired
	assign rdata_a = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rdata_b = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

// ==== program_counter.sv ====
`timescale 1ns/1ps
`include "sparc_params.svh"

module program_counter (
	input  logic               Clk,
	input  logic               RESET,
	input  logic               pc_load,
	input  logic               npc_load,
	input  sparc_pkg::pc_src_t npc_src,
	input  sparc_pkg::word_t   alu_result,
	output sparc_pkg::word_t   pc,
	output sparc_pkg::word_t   npc
);
	import sparc_pkg::*;

	always_ff @(posedge Clk) begin
		if (RESET) begin
			pc  <= `SPARC_RESET_PC;
			npc <= `SPARC_RESET_PC + 32'd4;
		end else begin
			if (pc_load)
				pc <= npc; // PC follows nPC
			if (npc_load)
				npc <= (npc_src == NPC_SRC_ALU) ? alu_result : npc + 32'd4;
		end
	end

endmodule

// ==== memory_interface.sv ====
`timescale 1ns/1ps

module memory_interface (
	input  logic             Clk,
	input  logic             RESET,
	input  logic             mar_load,
	input  logic             mdr_load,
	input  logic             mdr_from_mem,
	input  logic             start_read,
	input  logic             start_write,
	input  sparc_pkg::word_t alu_result,
	input  sparc_pkg::word_t mem_rdata,
	input  logic             mfc,
	output sparc_pkg::word_t mdr,
	output sparc_pkg::word_t mem_addr,
	output sparc_pkg::word_t mem_wdata,
	output logic             mem_read,
	output logic             mem_write
);
	import sparc_pkg::*;

	word_t mar;

	always_ff @(posedge Clk) begin
		if (mar_load)
			mar <= alu_result; // Effective address
		if (mdr_load) begin
			if (!mdr_from_mem)
				mdr <= alu_result;  // Store data from the register file
			else if (mfc)
				mdr <= mem_rdata;   // Read data is valid with mfc only
		end
	end

	// One-cycle strobes, aligned with MAR and MDR
	always_ff @(posedge Clk) begin
		if (RESET) begin
			mem_read  <= 1'b0;
			mem_write <= 1'b0;
		end else begin
			mem_read  <= start_read;
			mem_write <= start_write;
		end
	end

	assign mem_addr  = mar;
	assign mem_wdata = mdr;

endmodule

// ==== control_unit.sv ====
`timescale 1ns/1ps
`include "sparc_params.svh"

module control_unit (
	input  logic                    Clk,
	input  logic                    RESET,
	input  sparc_pkg::word_t        ir,
	input  logic                    ir_valid,
	input  logic                    mfc,
	output logic                    rf_write,
	output sparc_pkg::reg_idx_t     rs1_idx,
	output sparc_pkg::reg_idx_t     rs2_idx,
	output sparc_pkg::reg_idx_t     rd_idx,
	output sparc_pkg::op3_t         alu_op,
	output sparc_pkg::alub_sel_t    alub_sel,
	output sparc_pkg::ext_sel_t     ext_sel,
	output logic                    alua_is_zero,
	output logic                    mar_load,
	output logic                    mdr_load,
	output logic                    mdr_from_mem,
	output logic                    mem_start_read,
	output logic                    mem_start_write,
	output logic                    pc_load,
	output logic                    npc_load,
	output sparc_pkg::pc_src_t      npc_src,
	output logic                    done,
	output logic                    trap,
	output logic [`SPARC_TT_W-1:0]  tt
);
	import sparc_pkg::*;

	cu_state_t state, next_state;
	word_t     ir_q; // Instruction held for the whole sequence

	logic [1:0] op;
	op3_t       op3;
	logic       is_sethi, is_call, is_jmpl, is_alu, is_load, is_store, illegal;

	always_ff @(posedge Clk) begin
		if (RESET) begin
			state <= IDLE;
			ir_q  <= '0;
		end else begin
			state <= next_state;
			if (state == IDLE && ir_valid)
				ir_q <= ir; // Latch on the fetch strobe
		end
	end

	// Family decode from the latched word
	assign op       = ir_q[31:30];
	assign op3      = ir_q[24:19];
	assign is_sethi = (op == 2'b00) && (ir_q[24:22] == 3'b100);
	assign is_call  = (op == 2'b01);
	assign is_jmpl  = (op == 2'b10) && (op3 == OP3_JMPL);
	assign is_alu   = (op == 2'b10) && (op3[5:3] == 3'b000); // add .. xnor
	assign is_load  = (op == 2'b11) && (op3 == OP3_LD);
	assign is_store = (op == 2'b11) && (op3 == OP3_ST);
	assign illegal  = !(is_sethi || is_call || is_jmpl || is_alu || is_load || is_store);

	always_comb begin
		next_state = state;
		case (state)
			IDLE:       if (ir_valid) next_state = EXEC;
			EXEC: begin
				if (is_call || is_jmpl)
					next_state = CALL_LINK;
				else if (is_load || is_store)
					next_state = MEM_ADDR;
				else
					next_state = WRITE; // ALU, SETHI, illegal
			end
			MEM_ADDR:   next_state = is_store ? MEM_DATA : MEM_WAIT;
			MEM_DATA:   next_state = MEM_WAIT; // Store data goes out with the strobe
			MEM_WAIT:   if (mfc) next_state = WRITE;
			WRITE:      next_state = FINISH;
			CALL_LINK:  next_state = JMP_TARGET;
			JMP_TARGET: next_state = FINISH;
			FINISH:     next_state = IDLE;
			default:    next_state = IDLE;
		endcase
	end

	// Selects, from the latched fields and the state
	always_comb begin
		rs1_idx      = ir_q[18:14];
		rs2_idx      = ir_q[4:0];
		rd_idx       = ir_q[29:25];
		alu_op       = OP3_ADD;
		alua_is_zero = 1'b0;
		alub_sel     = ir_q[13] ? ALUB_EXT : ALUB_REG; // i bit picks simm13 or rs2
		ext_sel      = EXT_SIMM13;
		npc_src      = NPC_SRC_INC;
		if (is_sethi) begin
			alua_is_zero = 1'b1;      // r0 + imm22 << 10
			alub_sel     = ALUB_EXT;
			ext_sel      = EXT_IMM22;
		end else if (is_alu) begin
			alu_op = op3;
		end else if (is_call || is_jmpl) begin
			npc_src = NPC_SRC_ALU; // Only loaded in JMP_TARGET
			if (is_call)
				rd_idx = REG_O7;
			if (state == CALL_LINK) begin
				alua_is_zero = 1'b1; // Link value is the PC itself
				alub_sel     = ALUB_PC;
			end else if (is_call) begin
				rs1_idx  = REG_O7;     // r15 now holds the old PC
				alub_sel = ALUB_EXT;
				ext_sel  = EXT_DISP30;
			end
		end else if (is_load && state == WRITE) begin
			alua_is_zero = 1'b1;
			alub_sel     = ALUB_MDR; // Loaded word into rd
		end else if (is_store && state == MEM_DATA) begin
			alua_is_zero = 1'b1;
			alub_sel     = ALUB_REG;
			rs2_idx      = ir_q[29:25]; // Store data comes from rd
		end
	end

	// Enables, each only in its own state
	assign rf_write        = (state == WRITE && !illegal && !is_store) || (state == CALL_LINK);
	assign pc_load         = (state == WRITE && !illegal) || (state == CALL_LINK);
	assign npc_load        = (state == WRITE && !illegal) || (state == JMP_TARGET);
	assign mar_load        = (state == MEM_ADDR);
	assign mem_start_read  = (state == MEM_ADDR) && is_load;
	assign mem_start_write = (state == MEM_DATA);
	assign mdr_load        = (state == MEM_DATA) || (state == MEM_WAIT && is_load);
	assign mdr_from_mem    = is_load;
	assign trap            = (state == WRITE) && illegal; // No writes in this case
	assign tt              = trap ? `SPARC_TT_ILLEGAL : '0;
	assign done            = (state == FINISH);

endmodule

// ==== sparc_core.sv ====
`timescale 1ns/1ps
`include "sparc_params.svh"

module sparc_core (
	input  logic                   Clk,
	input  logic                   RESET,
	input  sparc_pkg::word_t       ir,
	input  logic                   ir_valid,
	input  sparc_pkg::word_t       mem_rdata,
	input  logic                   mfc,
	output sparc_pkg::word_t       mem_addr,
	output sparc_pkg::word_t       mem_wdata,
	output logic                   mem_read,
	output logic                   mem_write,
	output sparc_pkg::word_t       pc,
	output sparc_pkg::word_t       npc,
	output logic                   done,
	output logic                   trap,
	output logic [`SPARC_TT_W-1:0] tt
);
	import sparc_pkg::*;

	logic      rf_write, alua_is_zero, mar_load, mdr_load, mdr_from_mem;
	logic      mem_start_read, mem_start_write, pc_load, npc_load;
	reg_idx_t  rs1_idx, rs2_idx, rd_idx;
	op3_t      alu_op;
	alub_sel_t alub_sel;
	ext_sel_t  ext_sel;
	pc_src_t   npc_src;
	word_t     rdata_a, rdata_b, alu_result, mdr;

	control_unit i_cu (
		.Clk(Clk), .RESET(RESET), .ir(ir), .ir_valid(ir_valid), .mfc(mfc),
		.rf_write(rf_write), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rd_idx(rd_idx),
		.alu_op(alu_op), .alub_sel(alub_sel), .ext_sel(ext_sel),
		.alua_is_zero(alua_is_zero), .mar_load(mar_load), .mdr_load(mdr_load),
		.mdr_from_mem(mdr_from_mem), .mem_start_read(mem_start_read),
		.mem_start_write(mem_start_write), .pc_load(pc_load), .npc_load(npc_load),
		.npc_src(npc_src), .done(done), .trap(trap), .tt(tt)
	);

	register_file i_rf (
		.Clk(Clk), .RESET(RESET), .write(rf_write), .rs1_idx(rs1_idx),
		.rs2_idx(rs2_idx), .rd_idx(rd_idx), .wdata(alu_result), // ALU result to rd
		.rdata_a(rdata_a), .rdata_b(rdata_b)
	);

	alu i_alu (
		.op(alu_op), .rdata_a(rdata_a), .rdata_b(rdata_b), .alua_is_zero(alua_is_zero),
		.alub_sel(alub_sel), .ext_sel(ext_sel), .ir(ir), .pc(pc), .mdr(mdr),
		.result(alu_result)
	);

	program_counter i_pc (
		.Clk(Clk), .RESET(RESET), .pc_load(pc_load), .npc_load(npc_load),
		.npc_src(npc_src), .alu_result(alu_result), .pc(pc), .npc(npc)
	);

	memory_interface i_mem (
		.Clk(Clk), .RESET(RESET), .mar_load(mar_load), .mdr_load(mdr_load),
		.mdr_from_mem(mdr_from_mem), .start_read(mem_start_read),
		.start_write(mem_start_write), .alu_result(alu_result), .mem_rdata(mem_rdata),
		.mfc(mfc), .mdr(mdr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_read(mem_read), .mem_write(mem_write)
	);

endmodule

// ==== sparc_core_assertions.sv ====
`timescale 1ns/1ps

module sparc_core_assertions (
	input logic Clk,
	input logic RESET,
	input logic mem_start_read,
	input logic mem_start_write,
	input logic mfc,
	input logic rf_write,
	input logic done
);
	logic outstanding; // Strobe issued, mfc not yet seen

	always_ff @(posedge Clk) begin
		if (RESET)
			outstanding <= 1'b0;
		else if (mem_start_read || mem_start_write)
			outstanding <= 1'b1;
		else if (mfc)
			outstanding <= 1'b0; // Memory has answered
	end

	// One access at a time, so a read never overlaps a write
	a_one_access: assert property (@(posedge Clk) disable iff (RESET)
		(mem_start_read || mem_start_write) |-> !outstanding)
		else $error("new memory strobe while an access is outstanding");

	a_done_pulse: assert property (@(posedge Clk) disable iff (RESET)
		done |=> !done)
		else $error("done longer than one cycle");

	a_no_write_outstanding: assert property (@(posedge Clk) disable iff (RESET)
		outstanding |-> !rf_write)
		else $error("register write during memory access");

endmodule

bind control_unit sparc_core_assertions i_assert (
	.Clk(Clk), .RESET(RESET), .mem_start_read(mem_start_read),
	.mem_start_write(mem_start_write), .mfc(mfc), .rf_write(rf_write), .done(done)
);

// ==== tb_sparc_core.sv ====
`timescale 1ns/1ps
`include "sparc_params.svh"

module tb_sparc_core;
	import sparc_pkg::*;

	localparam int K_PC    = 0; // pc and npc only
	localparam int K_STORE = 1; // Store address and data too
	localparam int K_TRAP  = 2; // Trap pulse, nothing else moves

	logic                   Clk, RESET, ir_valid, mfc;
	word_t                  ir, mem_rdata, mem_addr, mem_wdata, pc, npc;
	logic                   mem_read, mem_write, done, trap;
	logic [`SPARC_TT_W-1:0] tt;

	sparc_core i_dut (.*);

	// Instruction table, one entry per row
	string t_name [$];
	word_t t_ir [$];
	word_t t_addr [$];
	word_t t_data [$];
	word_t t_pc [$];
	word_t t_npc [$];
	int    t_kind [$];

	word_t m_reg [32]; // Architectural state as the rules give it
	word_t m_pc, m_npc;
	word_t mem [word_t];
	int    errors, checks;

	initial begin
		Clk = 1'b0;
		forever #50 Clk = ~Clk;
	end

	// Memory model, answers each strobe after 1 to 4 cycles
	initial begin : memory_model
		int    lat;
		logic  busy;
		word_t req;
		mfc       = 1'b0;
		mem_rdata = '0;
		busy      = 1'b0;
		lat       = 0;
		req       = '0;
		forever begin
			@(negedge Clk);
			if (mfc) begin
				mfc = 1'b0;
			end else if (mem_read || mem_write) begin
				if (mem_write)
					mem[mem_addr] = mem_wdata;
				req  = mem_addr;
				lat  = int'($urandom % 4) + 1;
				busy = 1'b1;
			end else if (busy) begin
				lat--;
				if (lat == 0) begin
					busy      = 1'b0;
					mfc       = 1'b1;
					mem_rdata = mem.exists(req) ? mem[req] : (req ^ 32'hA5C3_5A3C); // Fill
				end
			end
		end
	end

	function automatic word_t sext13(input logic [12:0] s);
		return {{19{s[12]}}, s};
	endfunction

	function automatic word_t alu_rule(input logic [5:0] op, input word_t a, input word_t b);
		case (op)
			6'h01:   return a & b;
			6'h02:   return a | b;
			6'h03:   return a ^ b;
			6'h04:   return a - b;
			6'h05:   return a & ~b;
			6'h06:   return a | ~b;
			6'h07:   return ~(a ^ b);
			default: return a + b;
		endcase
	endfunction

	// Format 3 word, low13 is simm13 or {unused, rs2}
	function automatic word_t enc_fmt3(input logic [1:0] op, input logic [4:0] rd,
		input logic [5:0] op3, input logic [4:0] rs1, input logic i, input logic [12:0] low);
		return {op, rd, op3, rs1, i, low};
	endfunction

	task automatic advance_pc();
		m_pc  = m_npc;
		m_npc = m_npc + 32'd4;
	endtask

	// Expected pc and npc are the model state after the instruction
	task automatic queue_row(input string n, input word_t w, input word_t a, input word_t d,
		input int k);
		t_name.push_back(n);
		t_ir.push_back(w);
		t_addr.push_back(a);
		t_data.push_back(d);
		t_pc.push_back(m_pc);
		t_npc.push_back(m_npc);
		t_kind.push_back(k);
	endtask

	task automatic sethi_instr(input string n, input logic [4:0] rd, input logic [21:0] imm);
		if (rd != 0)
			m_reg[rd] = {imm, 10'b0};
		advance_pc();
		queue_row(n, {2'b00, rd, 3'b100, imm}, '0, '0, K_PC);
	endtask

	task automatic alu_instr(input string n, input logic [5:0] op3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic i, input logic [12:0] low);
		word_t b;
		b = i ? sext13(low) : m_reg[low[4:0]]; // Bit 13 picks the B operand
		if (rd != 0)
			m_reg[rd] = alu_rule(op3, m_reg[rs1], b);
		advance_pc();
		queue_row(n, enc_fmt3(2'b10, rd, op3, rs1, i, low), '0, '0, K_PC);
	endtask

	task automatic store_instr(input string n, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [12:0] simm);
		word_t a;
		a = m_reg[rs1] + sext13(simm);
		advance_pc();
		queue_row(n, enc_fmt3(2'b11, rd, 6'h04, rs1, 1'b1, simm), a, m_reg[rd], K_STORE);
	endtask

	task automatic load_instr(input string n, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [12:0] simm);
		word_t a;
		a = m_reg[rs1] + sext13(simm);
		if (rd != 0)
			m_reg[rd] = mem[a]; // Preloaded before the run
		advance_pc();
		queue_row(n, enc_fmt3(2'b11, rd, 6'h00, rs1, 1'b1, simm), '0, '0, K_PC);
	endtask

	task automatic call_instr(input string n, input logic [29:0] disp);
		word_t old_pc;
		old_pc    = m_pc;
		m_reg[15] = m_pc; // Link in r15
		m_pc      = m_npc;
		m_npc     = old_pc + {disp, 2'b00};
		queue_row(n, {2'b01, disp}, '0, '0, K_PC);
	endtask

	task automatic jmpl_instr(input string n, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [12:0] simm);
		word_t target;
		target = m_reg[rs1] + sext13(simm);
		if (rd != 0)
			m_reg[rd] = m_pc;
		m_pc  = m_npc;
		m_npc = target;
		queue_row(n, enc_fmt3(2'b10, rd, 6'h38, rs1, 1'b1, simm), '0, '0, K_PC);
	endtask

	task automatic check_word(input string n, input string what, input word_t exp,
		input word_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %s %s expected %h actual %h", n, what, exp, act);
		end
	endtask

	task automatic run_row(input int r);
		logic  got, seen_w, seen_r, seen_t;
		word_t wa, wd;
		logic [`SPARC_TT_W-1:0] tt_q;
		got    = 1'b0;
		seen_w = 1'b0;
		seen_r = 1'b0;
		seen_t = 1'b0;
		wa     = '0;
		wd     = '0;
		tt_q   = '0;
		@(negedge Clk);
		ir       = t_ir[r];
		ir_valid = 1'b1;
		@(negedge Clk);
		ir_valid = 1'b0; // Single pulse, ir stays until done
		for (int c = 0; c < 40 && !got; c++) begin
			if (mem_write) begin
				seen_w = 1'b1;
				wa     = mem_addr;
				wd     = mem_wdata;
			end
			if (mem_read)
				seen_r = 1'b1;
			if (trap) begin
				seen_t = 1'b1;
				tt_q   = tt;
			end
			if (done)
				got = 1'b1;
			else
				@(negedge Clk);
		end
		if (!got) begin
			errors++;
			$display("Timed out waiting for done on %s", t_name[r]);
			return;
		end
		check_word(t_name[r], "pc", t_pc[r], pc);
		check_word(t_name[r], "npc", t_npc[r], npc);
		if (t_kind[r] == K_STORE) begin
			if (!seen_w) begin
				errors++;
				$display("No memory write was seen on %s", t_name[r]);
			end else begin
				check_word(t_name[r], "store addr", t_addr[r], wa);
				check_word(t_name[r], "store data", t_data[r], wd);
			end
		end
		if (t_kind[r] == K_TRAP) begin
			if (!seen_t) begin
				errors++;
				$display("No trap pulse was seen on %s", t_name[r]);
			end else begin
				check_word(t_name[r], "tt", 32'(`SPARC_TT_ILLEGAL), 32'(tt_q));
			end
			if (seen_r || seen_w) begin
				errors++;
				$display("A memory strobe fired on the illegal instruction %s", t_name[r]);
			end
		end else if (seen_t) begin
			errors++;
			$display("Unexpected trap on %s", t_name[r]);
		end
	endtask

	initial begin
		word_t v1, v2;
		void'($urandom(19));
		RESET    = 1'b1;
		ir       = '0;
		ir_valid = 1'b0;
		errors   = 0;
		checks   = 0;
		repeat (10) @(negedge Clk);
		RESET = 1'b0;

		// Build the program against the model
		m_pc  = `SPARC_RESET_PC;
		m_npc = `SPARC_RESET_PC + 32'd4;
		for (int i = 0; i < 32; i++)
			m_reg[i] = '0;
		v1 = $urandom;
		v2 = $urandom;
		sethi_instr("sethi r1", 5'd1, v1[31:10]);
		alu_instr("or r1 low", 6'h02, 5'd1, 5'd1, 1'b1, {3'b0, v1[9:0]});
		sethi_instr("sethi r2", 5'd2, v2[31:10]);
		alu_instr("or r2 low", 6'h02, 5'd2, 5'd2, 1'b1, {3'b0, v2[9:0]});
		for (int k = 0; k < 8; k++) begin
			alu_instr($sformatf("alu op%0d reg", k), 6'(k), 5'd3, 5'd1, 1'b0, 13'd2);
			store_instr($sformatf("st op%0d", k), 5'd3, 5'd0, 13'(32'h100 + k * 4));
		end
		alu_instr("add imm neg", 6'h00, 5'd4, 5'd1, 1'b1, 13'h1FFB);
		store_instr("st add imm", 5'd4, 5'd0, 13'h140);
		alu_instr("xnor imm", 6'h07, 5'd4, 5'd1, 1'b1, 13'h0123);
		store_instr("st xnor imm", 5'd4, 5'd0, 13'h144);
		alu_instr("add to r0", 6'h00, 5'd0, 5'd1, 1'b1, 13'd7);
		store_instr("st r0", 5'd0, 5'd0, 13'h150); // r0 still zero
		alu_instr("or r6 base", 6'h02, 5'd6, 5'd0, 1'b1, 13'h300);
		for (int k = 0; k < 3; k++) begin
			mem[32'h300 + 32'(k * 8)] = $urandom;
			load_instr($sformatf("ld %0d", k), 5'd5, 5'd6, 13'(k * 8));
			store_instr($sformatf("st ld %0d", k), 5'd5, 5'd6, 13'(32'h40 + k * 4));
		end
		call_instr("call", 30'd16);
		store_instr("st r15", 5'd15, 5'd0, 13'h160);
		jmpl_instr("jmpl", 5'd7, 5'd6, 13'h020);
		store_instr("st r7", 5'd7, 5'd0, 13'h164);
		queue_row("illegal op3", enc_fmt3(2'b10, 5'd3, 6'h2A, 5'd1, 1'b1, 13'd5),
			'0, '0, K_TRAP);
		store_instr("st after trap", 5'd3, 5'd0, 13'h168); // rd of the trap row untouched

		for (int r = 0; r < t_ir.size(); r++)
			run_row(r);

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+.
sparc_pkg.sv
operand_extender.sv
alu.sv
register_file.sv
program_counter.sv
memory_interface.sv
control_unit.sv
sparc_core.sv
sparc_core_assertions.sv
tb_sparc_core.sv

// ==== Makefile ====
TOP = tb_sparc_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
